//--- verilog/kuz_pkg.sv
`default_nettype none

package kuz_pkg;

  // **********************************************************************
  // basic types.
  // **********************************************************************

  typedef logic [127:0] block_t;
  typedef logic [255:0] key_t;
  typedef logic [3:0]   key_idx_t;

  typedef enum logic {
    OP_ENCRYPT,
    OP_DECRYPT
  } op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXPAND,
    ST_READY,
    ST_CRYPT
  } state_e;

  typedef struct packed {
    op_e    op;
    block_t data;
  } crypt_req_t;

  // feistel iterations of the key schedule, eight per round-key pair.
  localparam int unsigned KEY_ITERS = 32;
  // full rounds, the tenth key is only xored.
  localparam int unsigned ROUNDS = 9;

  // **********************************************************************
  // substitution pi and its inverse.
  // **********************************************************************

  localparam logic [7:0] SBOX_FWD [256] = '{
    252, 238, 221, 17, 207, 110, 49, 22, 251, 196, 250, 218, 35, 197, 4, 77,
    233, 119, 240, 219, 147, 46, 153, 186, 23, 54, 241, 187, 20, 205, 95, 193,
    249, 24, 101, 90, 226, 92, 239, 33, 129, 28, 60, 66, 139, 1, 142, 79,
    5, 132, 2, 174, 227, 106, 143, 160, 6, 11, 237, 152, 127, 212, 211, 31,
    235, 52, 44, 81, 234, 200, 72, 171, 242, 42, 104, 162, 253, 58, 206, 204,
    181, 112, 14, 86, 8, 12, 118, 18, 191, 114, 19, 71, 156, 183, 93, 135,
    21, 161, 150, 41, 16, 123, 154, 199, 243, 145, 120, 111, 157, 158, 178, 177,
    50, 117, 25, 61, 255, 53, 138, 126, 109, 84, 198, 128, 195, 189, 13, 87,
    223, 245, 36, 169, 62, 168, 67, 201, 215, 121, 214, 246, 124, 34, 185, 3,
    224, 15, 236, 222, 122, 148, 176, 188, 220, 232, 40, 80, 78, 51, 10, 74,
    167, 151, 96, 115, 30, 0, 98, 68, 26, 184, 56, 130, 100, 159, 38, 65,
    173, 69, 70, 146, 39, 94, 85, 47, 140, 163, 165, 125, 105, 213, 149, 59,
    7, 88, 179, 64, 134, 172, 29, 247, 48, 55, 107, 228, 136, 217, 231, 137,
    225, 27, 131, 73, 76, 63, 248, 254, 141, 83, 170, 144, 202, 216, 133, 97,
    32, 113, 103, 164, 45, 43, 9, 91, 203, 155, 37, 208, 190, 229, 108, 82,
    89, 166, 116, 210, 230, 244, 180, 192, 209, 102, 175, 194, 57, 75, 99, 182
  };

  localparam logic [7:0] SBOX_INV [256] = '{
    165, 45, 50, 143, 14, 48, 56, 192, 84, 230, 158, 57, 85, 126, 82, 145,
    100, 3, 87, 90, 28, 96, 7, 24, 33, 114, 168, 209, 41, 198, 164, 63,
    224, 39, 141, 12, 130, 234, 174, 180, 154, 99, 73, 229, 66, 228, 21, 183,
    200, 6, 112, 157, 65, 117, 25, 201, 170, 252, 77, 191, 42, 115, 132, 213,
    195, 175, 43, 134, 167, 177, 178, 91, 70, 211, 159, 253, 212, 15, 156, 47,
    155, 67, 239, 217, 121, 182, 83, 127, 193, 240, 35, 231, 37, 94, 181, 30,
    162, 223, 166, 254, 172, 34, 249, 226, 74, 188, 53, 202, 238, 120, 5, 107,
    81, 225, 89, 163, 242, 113, 86, 17, 106, 137, 148, 101, 140, 187, 119, 60,
    123, 40, 171, 210, 49, 222, 196, 95, 204, 207, 118, 44, 184, 216, 46, 54,
    219, 105, 179, 20, 149, 190, 98, 161, 59, 22, 102, 233, 92, 108, 109, 173,
    55, 97, 75, 185, 227, 186, 241, 160, 133, 131, 218, 71, 197, 176, 51, 250,
    150, 111, 110, 194, 246, 80, 255, 93, 169, 142, 23, 27, 151, 125, 236, 88,
    247, 31, 251, 124, 9, 13, 122, 103, 69, 135, 220, 232, 79, 29, 78, 4,
    235, 248, 243, 62, 61, 189, 138, 136, 221, 205, 11, 19, 152, 2, 147, 128,
    144, 208, 36, 52, 203, 237, 244, 206, 153, 16, 68, 64, 146, 58, 1, 38,
    18, 26, 72, 104, 245, 129, 139, 199, 214, 32, 10, 8, 0, 76, 215, 116
  };

  // **********************************************************************
  // linear feedback, coefficient 0 weights the most significant byte.
  // **********************************************************************

  localparam logic [7:0] LIN_COEF [16] = '{
    148, 32, 133, 16, 194, 192, 1, 251,
    1, 192, 194, 16, 133, 32, 148, 1
  };

  // shift-and-add multiply, reduced by x^8+x^7+x^6+x+1.
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] prod;
    logic [7:0] acc;
    prod = '0;
    acc  = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        prod = prod ^ acc;
      end
      acc = {acc[6:0], 1'b0} ^ (acc[7] ? 8'hc3 : 8'h00);
    end
    return prod;
  endfunction

endpackage

`default_nettype wire

//--- verilog/kuz_sbox_layer.sv
`timescale 1ns/1ps
`default_nettype none

module kuz_sbox_layer #(
  parameter bit INVERSE = 1'b0
) (
  input  kuz_pkg::block_t in_i,
  output kuz_pkg::block_t out_o
);

  for (genvar i = 0; i < 16; i++) begin : g_byte
    if (INVERSE) begin : g_inv
      assign out_o[8*i +: 8] = kuz_pkg::SBOX_INV[in_i[8*i +: 8]];
    end else begin : g_fwd
      assign out_o[8*i +: 8] = kuz_pkg::SBOX_FWD[in_i[8*i +: 8]];
    end
  end

endmodule

`default_nettype wire

//--- verilog/kuz_lin_transform.sv
`timescale 1ns/1ps
`default_nettype none

module kuz_lin_transform #(
  parameter bit INVERSE = 1'b0
) (
  input  kuz_pkg::block_t in_i,
  output kuz_pkg::block_t out_o
);

  kuz_pkg::block_t stage [17];

  assign stage[0] = in_i;

  // sixteen R steps in a chain.
  for (genvar r = 0; r < 16; r++) begin : g_step
    kuz_pkg::block_t src;
    logic [7:0]      fb;

    // the inverse step rotates left before weighting.
    assign src = INVERSE ? {stage[r][119:0], stage[r][127:120]} : stage[r];

    always_comb begin
      fb = '0;
      for (int b = 0; b < 16; b++) begin
        fb = fb ^ kuz_pkg::gf_mul(src[127 - 8*b -: 8], kuz_pkg::LIN_COEF[b]);
      end
    end

    assign stage[r+1] = INVERSE ? {stage[r][119:0], fb} : {fb, stage[r][127:8]};
  end

  assign out_o = stage[16];

endmodule

`default_nettype wire

//--- verilog/kuz_round_counter.sv
`timescale 1ns/1ps
`default_nettype none

module kuz_round_counter #(
  parameter int unsigned CNT_W = 5
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             load_i,
  input  logic [CNT_W-1:0] init_i,
  output logic [CNT_W-1:0] count_o,
  output logic             last_o
);

  logic [CNT_W-1:0] count_q;

  // parks at zero once run out.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= init_i;
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign count_o = count_q;
  assign last_o  = (count_q == '0);

endmodule

`default_nettype wire

//--- verilog/kuz_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module kuz_ctrl_fsm #(
  parameter int unsigned CNT_W = 5
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              key_load_i,
  input  logic              start_i,
  input  kuz_pkg::op_e      req_op_i,
  input  logic [CNT_W-1:0]  count_i,
  input  logic              last_i,
  output logic              cnt_load_o,
  output logic [CNT_W-1:0]  cnt_init_o,
  output logic              exp_start_o,
  output logic              exp_step_o,
  output kuz_pkg::key_idx_t key_sel_o,
  output logic              load_o,
  output logic              round_en_o,
  output logic              finish_o,
  output kuz_pkg::op_e      op_o,
  output logic              key_ready_o
);

  localparam logic [CNT_W-1:0] INIT_EXP = CNT_W'(kuz_pkg::KEY_ITERS - 1);
  localparam logic [CNT_W-1:0] INIT_RND = CNT_W'(kuz_pkg::ROUNDS - 1);
  localparam kuz_pkg::key_idx_t LAST_KEY = 4'(kuz_pkg::ROUNDS);

  kuz_pkg::state_e state_q;
  kuz_pkg::state_e state_d;
  kuz_pkg::op_e    op_q;
  logic            fin_q;
  logic            key_ready_q;
  logic            accept_key;
  logic            accept_blk;

  // a key load wins over a start in the same cycle.
  assign accept_key = key_load_i &&
                      (state_q == kuz_pkg::ST_IDLE || state_q == kuz_pkg::ST_READY);
  assign accept_blk = start_i && !key_load_i && key_ready_q &&
                      (state_q == kuz_pkg::ST_READY);

  always_comb begin
    state_d = state_q;
    case (state_q)
      kuz_pkg::ST_IDLE: begin
        if (accept_key) begin
          state_d = kuz_pkg::ST_EXPAND;
        end
      end
      kuz_pkg::ST_EXPAND: begin
        if (last_i) begin
          state_d = kuz_pkg::ST_READY;
        end
      end
      kuz_pkg::ST_READY: begin
        if (accept_key) begin
          state_d = kuz_pkg::ST_EXPAND;
        end else if (accept_blk) begin
          state_d = kuz_pkg::ST_CRYPT;
        end
      end
      kuz_pkg::ST_CRYPT: begin
        if (fin_q) begin
          state_d = kuz_pkg::ST_READY;
        end
      end
      default: state_d = kuz_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= kuz_pkg::ST_IDLE;
      op_q        <= kuz_pkg::OP_ENCRYPT;
      fin_q       <= 1'b0;
      key_ready_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      fin_q       <= round_en_o && last_i;
      // trails the state by one cycle.
      key_ready_q <= (state_q == kuz_pkg::ST_READY) || (state_q == kuz_pkg::ST_CRYPT);
      if (accept_blk) begin
        op_q <= req_op_i;
      end
    end
  end

  assign cnt_load_o  = accept_key || accept_blk;
  assign cnt_init_o  = accept_key ? INIT_EXP : INIT_RND;
  assign exp_start_o = accept_key;
  assign exp_step_o  = (state_q == kuz_pkg::ST_EXPAND);
  assign load_o      = accept_blk;
  assign round_en_o  = (state_q == kuz_pkg::ST_CRYPT) && !fin_q;
  assign finish_o    = fin_q;
  assign op_o        = accept_blk ? req_op_i : op_q;
  assign key_ready_o = key_ready_q;

  // encrypt walks K1 up to K10, decrypt starts at K10 and walks down.
  always_comb begin
    if (accept_blk) begin
      key_sel_o = (req_op_i == kuz_pkg::OP_DECRYPT) ? LAST_KEY : '0;
    end else if (op_q == kuz_pkg::OP_ENCRYPT) begin
      key_sel_o = fin_q ? LAST_KEY : kuz_pkg::key_idx_t'(kuz_pkg::ROUNDS - 1 - count_i);
    end else begin
      key_sel_o = kuz_pkg::key_idx_t'(count_i);
    end
  end

endmodule

`default_nettype wire

//--- verilog/kuz_key_expander.sv
`timescale 1ns/1ps
`default_nettype none

module kuz_key_expander #(
  parameter int unsigned CNT_W = 5
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  kuz_pkg::key_t     key_i,
  input  logic              start_i,
  input  logic              step_i,
  input  logic [CNT_W-1:0]  iter_i,
  input  kuz_pkg::key_idx_t sel_i,
  output kuz_pkg::block_t   round_key_o
);

  kuz_pkg::block_t left_q;
  kuz_pkg::block_t right_q;
  kuz_pkg::block_t key_mem [10];
  kuz_pkg::block_t const_in;
  kuz_pkg::block_t const_c;
  kuz_pkg::block_t sub_out;
  kuz_pkg::block_t lin_out;
  kuz_pkg::block_t left_next;
  logic [7:0]      iter_j;

  // iteration number, 1 to 32, from the down count.
  assign iter_j   = 8'(kuz_pkg::KEY_ITERS) - 8'(iter_i);
  assign const_in = {120'd0, iter_j};

  // C_j = L(j).
  kuz_lin_transform #(.INVERSE(1'b0)) i_lin_const (
    .in_i  (const_in),
    .out_o (const_c)
  );

  kuz_sbox_layer #(.INVERSE(1'b0)) i_sbox_f (
    .in_i  (left_q ^ const_c),
    .out_o (sub_out)
  );

  kuz_lin_transform #(.INVERSE(1'b0)) i_lin_f (
    .in_i  (sub_out),
    .out_o (lin_out)
  );

  assign left_next = lin_out ^ right_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      left_q  <= '0;
      right_q <= '0;
    end else if (start_i) begin
      left_q  <= key_i[255:128];
      right_q <= key_i[127:0];
    end else if (step_i) begin
      left_q  <= left_next;
      right_q <= left_q;
    end
  end

  // K1 and K2 are the key halves, each eighth iteration yields the next pair.
  always_ff @(posedge clk_i) begin
    if (step_i) begin
      if (iter_j == 8'd1) begin
        key_mem[0] <= left_q;
        key_mem[1] <= right_q;
      end
      if (iter_j[2:0] == 3'd0) begin
        key_mem[iter_j[5:2]]        <= left_next;
        key_mem[iter_j[5:2] + 4'd1] <= left_q;
      end
    end
  end

  assign round_key_o = key_mem[sel_i];

endmodule

`default_nettype wire

//--- verilog/kuz_block_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module kuz_block_datapath (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            load_i,
  input  logic            round_en_i,
  input  logic            finish_i,
  input  kuz_pkg::op_e    op_i,
  input  kuz_pkg::block_t data_i,
  input  kuz_pkg::block_t round_key_i,
  output kuz_pkg::block_t block_o,
  output logic            done_o
);

  kuz_pkg::block_t state_q;
  kuz_pkg::block_t enc_sub;
  kuz_pkg::block_t enc_next;
  kuz_pkg::block_t dec_lin;
  kuz_pkg::block_t dec_sub;
  logic            is_enc;

  assign is_enc = (op_i == kuz_pkg::OP_ENCRYPT);

  // **********************************************************************
  // encrypt round, L(S(x ^ k)).
  // **********************************************************************

  kuz_sbox_layer #(.INVERSE(1'b0)) i_sbox_fwd (
    .in_i  (state_q ^ round_key_i),
    .out_o (enc_sub)
  );

  kuz_lin_transform #(.INVERSE(1'b0)) i_lin_fwd (
    .in_i  (enc_sub),
    .out_o (enc_next)
  );

  // **********************************************************************
  // decrypt round, k ^ S^-1(L^-1(x)).
  // **********************************************************************

  kuz_lin_transform #(.INVERSE(1'b1)) i_lin_inv (
    .in_i  (state_q),
    .out_o (dec_lin)
  );

  kuz_sbox_layer #(.INVERSE(1'b1)) i_sbox_inv (
    .in_i  (dec_lin),
    .out_o (dec_sub)
  );

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      state_q <= is_enc ? data_i : (data_i ^ round_key_i);
    end else if (round_en_i) begin
      state_q <= is_enc ? enc_next : (dec_sub ^ round_key_i);
    end
    if (finish_i) begin
      block_o <= is_enc ? (state_q ^ round_key_i) : state_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= finish_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/kuz_cipher_top.sv
`timescale 1ns/1ps
`default_nettype none

module kuz_cipher_top #(
  parameter int unsigned CNT_W = 5
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                key_load_i,
  input  kuz_pkg::key_t       key_i,
  input  logic                start_i,
  input  kuz_pkg::crypt_req_t req_i,
  output logic                key_ready_o,
  output logic                done_o,
  output kuz_pkg::block_t     block_o
);

  logic              cnt_load;
  logic [CNT_W-1:0]  cnt_init;
  logic [CNT_W-1:0]  cnt_count;
  logic              cnt_last;
  logic              exp_start;
  logic              exp_step;
  kuz_pkg::key_idx_t key_sel;
  logic              dp_load;
  logic              round_en;
  logic              finish;
  kuz_pkg::op_e      op;
  kuz_pkg::block_t   round_key;

  kuz_ctrl_fsm #(.CNT_W(CNT_W)) i_ctrl_fsm (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .key_load_i  (key_load_i),
    .start_i     (start_i),
    .req_op_i    (req_i.op),
    .count_i     (cnt_count),
    .last_i      (cnt_last),
    .cnt_load_o  (cnt_load),
    .cnt_init_o  (cnt_init),
    .exp_start_o (exp_start),
    .exp_step_o  (exp_step),
    .key_sel_o   (key_sel),
    .load_o      (dp_load),
    .round_en_o  (round_en),
    .finish_o    (finish),
    .op_o        (op),
    .key_ready_o (key_ready_o)
  );

  // one counter serves both key expansion and the rounds.
  kuz_round_counter #(.CNT_W(CNT_W)) i_round_counter (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .load_i  (cnt_load),
    .init_i  (cnt_init),
    .count_o (cnt_count),
    .last_o  (cnt_last)
  );

  kuz_key_expander #(.CNT_W(CNT_W)) i_key_expander (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .key_i       (key_i),
    .start_i     (exp_start),
    .step_i      (exp_step),
    .iter_i      (cnt_count),
    .sel_i       (key_sel),
    .round_key_o (round_key)
  );

  kuz_block_datapath i_block_datapath (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .load_i      (dp_load),
    .round_en_i  (round_en),
    .finish_i    (finish),
    .op_i        (op),
    .data_i      (req_i.data),
    .round_key_i (round_key),
    .block_o     (block_o),
    .done_o      (done_o)
  );

endmodule

`default_nettype wire

//--- bench/kuz_cipher_chk.sv
`timescale 1ns/1ps
`default_nettype none

module kuz_cipher_chk (
  input logic clk_i,
  input logic rst_n_i,
  input logic key_ready_i,
  input logic done_i,
  input logic key_load_i
);

  int unsigned fail_cnt = 0;

  // outputs stay low while reset is held.
  reset_low: assert property (@(posedge clk_i) !rst_n_i |-> !key_ready_i && !done_i)
    else begin
      fail_cnt++;
      $error("key_ready_o or done_o high during reset");
    end

  done_single: assert property (@(posedge clk_i) disable iff (!rst_n_i) done_i |=> !done_i)
    else begin
      fail_cnt++;
      $error("done_o held for more than one cycle");
    end

  done_keyed: assert property (@(posedge clk_i) disable iff (!rst_n_i) done_i |-> key_ready_i)
    else begin
      fail_cnt++;
      $error("done_o pulsed without round keys ready");
    end

  // key_ready_o only drops in the second cycle after a key load.
  ready_drop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                               $fell(key_ready_i) |-> $past(key_load_i, 2))
    else begin
      fail_cnt++;
      $error("key_ready_o dropped without a key load");
    end

endmodule

`default_nettype wire

//--- bench/kuz_cipher_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module kuz_cipher_monitor (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                key_load_i,
  input  kuz_pkg::key_t       key_i,
  input  logic                start_i,
  input  kuz_pkg::crypt_req_t req_i,
  input  logic                key_ready_i,
  input  logic                done_i,
  input  kuz_pkg::block_t     block_i,
  output int unsigned         err_cnt_o,
  output int unsigned         chk_cnt_o
);

  localparam kuz_pkg::key_t KAT_KEY =
    256'h8899aabbccddeeff0011223344556677fedcba98765432100123456789abcdef;
  localparam kuz_pkg::block_t KAT_PT = 128'h1122334455667700ffeeddccbbaa9988;
  localparam kuz_pkg::block_t KAT_CT = 128'h7f679d90bebc24305a468d42b9d4edcd;

  kuz_pkg::block_t    mk [10];
  kuz_pkg::block_t    exp_q [$];
  kuz_pkg::crypt_req_t in_q [$];
  kuz_pkg::block_t    pt_seen = '0;
  kuz_pkg::block_t    ct_seen = '0;
  int unsigned        errs = 0;
  int unsigned        checks = 0;
  int unsigned        exp_left = 0;
  int unsigned        crypt_left = 0;
  int unsigned        kr_cnt = 0;
  logic               kr_exp = 1'b0;
  logic               done_exp = 1'b0;

  assign err_cnt_o = errs;
  assign chk_cnt_o = checks;

  // ********************************************************************
  // behavioral cipher model.
  // ********************************************************************

  // horner form multiply in gf(2^8).
  function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    p = '0;
    for (int i = 7; i >= 0; i--) begin
      p = {p[6:0], 1'b0} ^ (p[7] ? 8'hc3 : 8'h00);
      if (a[i]) p = p ^ b;
    end
    return p;
  endfunction

  function automatic logic [7:0] lfb(input kuz_pkg::block_t x);
    logic [7:0] fb;
    fb = '0;
    for (int b = 0; b < 16; b++) begin
      fb = fb ^ gmul(x[127 - 8*b -: 8], kuz_pkg::LIN_COEF[b]);
    end
    return fb;
  endfunction

  function automatic kuz_pkg::block_t lin(input kuz_pkg::block_t x, input bit inv);
    for (int r = 0; r < 16; r++) begin
      x = inv ? {x[119:0], lfb({x[119:0], x[127:120]})} : {lfb(x), x[127:8]};
    end
    return x;
  endfunction

  function automatic kuz_pkg::block_t sub(input kuz_pkg::block_t x, input bit inv);
    for (int i = 0; i < 16; i++) begin
      x[8*i +: 8] = inv ? kuz_pkg::SBOX_INV[x[8*i +: 8]] : kuz_pkg::SBOX_FWD[x[8*i +: 8]];
    end
    return x;
  endfunction

  task automatic expand_key(input kuz_pkg::key_t key);
    kuz_pkg::block_t a;
    kuz_pkg::block_t b;
    kuz_pkg::block_t t;
    a = key[255:128];
    b = key[127:0];
    mk[0] = a;
    mk[1] = b;
    for (int i = 1; i <= 32; i++) begin
      t = lin(sub(a ^ lin(128'(i), 1'b0), 1'b0), 1'b0) ^ b;
      b = a;
      a = t;
      if (i % 8 == 0) begin
        mk[i / 4] = a;
        mk[i / 4 + 1] = b;
      end
    end
  endtask

  function automatic kuz_pkg::block_t encrypt(input kuz_pkg::block_t x);
    for (int i = 0; i < 9; i++) x = lin(sub(x ^ mk[i], 1'b0), 1'b0);
    return x ^ mk[9];
  endfunction

  function automatic kuz_pkg::block_t decrypt(input kuz_pkg::block_t x);
    x = x ^ mk[9];
    for (int i = 8; i >= 0; i--) x = sub(lin(x, 1'b1), 1'b1) ^ mk[i];
    return x;
  endfunction

  // the model itself must reproduce the standard vector.
  initial begin
    expand_key(KAT_KEY);
    if (encrypt(KAT_PT) !== KAT_CT || decrypt(KAT_CT) !== KAT_PT) begin
      errs++;
      $display("model does not reproduce the known-answer vector");
    end
  end

  // ********************************************************************
  // expected timing of the core, updated on every edge.
  // ********************************************************************

  always @(posedge clk_i or negedge rst_n_i) begin
    logic            kr_before;
    logic            busy;
    kuz_pkg::block_t res;
    if (!rst_n_i) begin
      exp_left = 0;
      crypt_left = 0;
      kr_cnt = 0;
      kr_exp = 1'b0;
      done_exp = 1'b0;
      exp_q.delete();
      in_q.delete();
    end else begin
      kr_before = kr_exp;
      busy = (exp_left != 0) || (crypt_left != 0);
      done_exp = 1'b0;
      if (exp_left != 0) exp_left--;
      if (crypt_left != 0) begin
        crypt_left--;
        if (crypt_left == 0) done_exp = 1'b1;
      end
      if (kr_cnt != 0) begin
        kr_cnt--;
        if (kr_cnt == 32) kr_exp = 1'b0;
        if (kr_cnt == 0) kr_exp = 1'b1;
      end
      if (key_load_i && !busy) begin
        expand_key(key_i);
        exp_left = 32;
        kr_cnt = 33;
      end else if (start_i && kr_before && !busy) begin
        if (req_i.op == kuz_pkg::OP_ENCRYPT) begin
          res = encrypt(req_i.data);
        end else begin
          res = decrypt(req_i.data);
          if (req_i.data == ct_seen && res !== pt_seen) begin
            errs++;
            $display("model decrypt does not undo the last encrypt");
          end
        end
        exp_q.push_back(res);
        in_q.push_back(req_i);
        crypt_left = 10;
      end
    end
  end

  always @(negedge clk_i) begin
    kuz_pkg::block_t     want;
    kuz_pkg::crypt_req_t req;
    if (rst_n_i) begin
      if (key_ready_i !== kr_exp) begin
        errs++;
        $display("FAILED at %0t: key_ready_o expected %b, got %b", $time, kr_exp, key_ready_i);
      end
      if (done_i && !done_exp) begin
        errs++;
        $display("unexpected done_o pulse at %0t with no block in flight", $time);
      end else if (done_exp) begin
        want = exp_q.pop_front();
        req = in_q.pop_front();
        checks++;
        if (!done_i) begin
          errs++;
          $display("done_o missing at %0t for a started block", $time);
        end else if (block_i !== want) begin
          errs++;
          $display("FAILED at %0t: block_o expected %h, got %h", $time, want, block_i);
        end else if (req.op == kuz_pkg::OP_ENCRYPT) begin
          pt_seen = req.data;
          ct_seen = block_i;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/kuz_cipher_tb.sv
`timescale 1ns/1ps
`default_nettype none

module kuz_cipher_tb;

  localparam int unsigned N_KEYS = 7;
  localparam int unsigned N_BLOCKS = 31;
  localparam int unsigned LIMIT = N_KEYS * 40 + N_BLOCKS * 12 + 100;

  localparam kuz_pkg::key_t KAT_KEY =
    256'h8899aabbccddeeff0011223344556677fedcba98765432100123456789abcdef;
  localparam kuz_pkg::block_t KAT_PT = 128'h1122334455667700ffeeddccbbaa9988;

  logic                clk_i;
  logic                rst_n_i;
  logic                key_load_i;
  kuz_pkg::key_t       key_i;
  logic                start_i;
  kuz_pkg::crypt_req_t req_i;
  logic                key_ready_o;
  logic                done_o;
  kuz_pkg::block_t     block_o;
  int unsigned         mon_errs;
  int unsigned         mon_checks;
  integer              seed = 32'h67d;

  kuz_cipher_top #(.CNT_W(5)) i_kuz_cipher_top (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .key_load_i  (key_load_i),
    .key_i       (key_i),
    .start_i     (start_i),
    .req_i       (req_i),
    .key_ready_o (key_ready_o),
    .done_o      (done_o),
    .block_o     (block_o)
  );

  kuz_cipher_monitor i_monitor (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .key_load_i  (key_load_i),
    .key_i       (key_i),
    .start_i     (start_i),
    .req_i       (req_i),
    .key_ready_i (key_ready_o),
    .done_i      (done_o),
    .block_i     (block_o),
    .err_cnt_o   (mon_errs),
    .chk_cnt_o   (mon_checks)
  );

  bind kuz_cipher_top kuz_cipher_chk i_chk (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .key_ready_i (key_ready_o),
    .done_i      (done_o),
    .key_load_i  (key_load_i)
  );

  always #50 clk_i = ~clk_i;

  // ********************************************************************
  // stimulus helpers.
  // ********************************************************************

  function automatic kuz_pkg::block_t rand_block();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic idle(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic pulse_key(input kuz_pkg::key_t k);
    @(posedge clk_i);
    key_load_i <= 1'b1;
    key_i <= k;
    @(posedge clk_i);
    key_load_i <= 1'b0;
  endtask

  task automatic pulse_start(input kuz_pkg::op_e op, input kuz_pkg::block_t d);
    @(posedge clk_i);
    start_i <= 1'b1;
    req_i.op <= op;
    req_i.data <= d;
    @(posedge clk_i);
    start_i <= 1'b0;
  endtask

  // key_ready_o falls one cycle after the load, then rises when expansion ends.
  task automatic wait_ready();
    repeat (2) @(negedge clk_i);
    while (!key_ready_o) @(negedge clk_i);
  endtask

  task automatic wait_done(output kuz_pkg::block_t res);
    do @(negedge clk_i); while (!done_o);
    res = block_o;
  endtask

  task automatic round_trip(input kuz_pkg::block_t d);
    kuz_pkg::block_t ct;
    kuz_pkg::block_t pt;
    pulse_start(kuz_pkg::OP_ENCRYPT, d);
    wait_done(ct);
    pulse_start(kuz_pkg::OP_DECRYPT, ct);
    wait_done(pt);
  endtask

  // ********************************************************************
  // test sequence.
  // ********************************************************************

  initial begin
    kuz_pkg::block_t res;
    int unsigned     total;
    clk_i = 1'b0;
    rst_n_i = 1'b1;
    key_load_i = 1'b0;
    key_i = '0;
    start_i = 1'b0;
    req_i = '0;
    #1 rst_n_i = 1'b0;
    idle(4);
    rst_n_i <= 1'b1;
    // no key yet, so this start is dropped.
    pulse_start(kuz_pkg::OP_ENCRYPT, rand_block());
    idle(12);
    pulse_key(KAT_KEY);
    pulse_start(kuz_pkg::OP_ENCRYPT, rand_block());
    wait_ready();
    round_trip(KAT_PT);
    for (int k = 0; k < 4; k++) begin
      pulse_key({rand_block(), rand_block()});
      wait_ready();
      for (int b = 0; b < 3; b++) round_trip(rand_block());
    end
    // second start while a block is in flight.
    pulse_start(kuz_pkg::OP_ENCRYPT, rand_block());
    idle(3);
    pulse_start(kuz_pkg::OP_ENCRYPT, rand_block());
    wait_done(res);
    idle(12);
    // key load during a run keeps the old keys.
    pulse_start(kuz_pkg::OP_DECRYPT, rand_block());
    idle(2);
    pulse_key({rand_block(), rand_block()});
    wait_done(res);
    idle(3);
    pulse_key({rand_block(), rand_block()});
    wait_ready();
    pulse_start(kuz_pkg::OP_ENCRYPT, rand_block());
    wait_done(res);
    idle(5);
    total = mon_errs + i_kuz_cipher_top.i_chk.fail_cnt;
    $display("closing: %0d monitor errors, %0d assertion failures, %0d results checked",
             mon_errs, i_kuz_cipher_top.i_chk.fail_cnt, mon_checks);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    repeat (LIMIT) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", LIMIT);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- kuz_cipher_top.f
verilog/kuz_pkg.sv
verilog/kuz_sbox_layer.sv
verilog/kuz_lin_transform.sv
verilog/kuz_round_counter.sv
verilog/kuz_ctrl_fsm.sv
verilog/kuz_key_expander.sv
verilog/kuz_block_datapath.sv
verilog/kuz_cipher_top.sv
bench/kuz_cipher_chk.sv
bench/kuz_cipher_monitor.sv
bench/kuz_cipher_tb.sv
